// File: Bender.yml
package:
  name: mem_subsystem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mem_pkg.sv
      - verilog/mem_control.sv
      - verilog/store_align.sv
      - verilog/byte_ram.sv
      - verilog/io_port.sv
      - verilog/load_extract.sv
      - verilog/mem_subsystem.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/mem_subsystem_tb.sv

// File: compile.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_control.sv
verilog/store_align.sv
verilog/byte_ram.sv
verilog/io_port.sv
verilog/load_extract.sv
verilog/mem_subsystem.sv
testbench/mem_subsystem_tb.sv

// File: testbench/mem_subsystem_tb.sv
// Self-checking testbench for mem_subsystem, replays testbench/mem_vectors.txt one access per cycle
`include "riscv_mem_defs.svh"

module mem_subsystem_tb import mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD = 40;
    localparam int    MAX_VEC    = 64;
    localparam int    FIELDS     = 9;
    localparam string VEC_FILE   = "testbench/mem_vectors.txt";

    logic       clk;
    logic       reset;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      addr;
    word_t      store_data;
    word_t      fetch_addr;
    word_t      io_rx_data;
    word_t      load_data;
    word_t      fetch_instr;
    word_t      io_tx_data;
    lane_mask_t io_tx_lanes;
    logic       io_recv;

    // Nine hex fields per vector, flat
    word_t vec_raw [MAX_VEC*FIELDS];
    int    vec_errs [MAX_VEC];
    int    vec_count  = 0;
    bit    vec_loaded = 1'b0;
    int    errors     = 0;
    int    passed     = 0;
    int    failed     = 0;

    mem_subsystem mem_subsystem_inst (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct3      (funct3),
        .addr        (addr),
        .store_data  (store_data),
        .fetch_addr  (fetch_addr),
        .io_rx_data  (io_rx_data),
        .load_data   (load_data),
        .fetch_instr (fetch_instr),
        .io_tx_data  (io_tx_data),
        .io_tx_lanes (io_tx_lanes),
        .io_recv     (io_recv)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_lanes(input string name, input lane_mask_t got, input lane_mask_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Columns: opcode funct3 addr store rx load tx lanes flags
    function automatic word_t vec_field(input int k, input int f);
        return vec_raw[k*FIELDS + f];
    endfunction

    function automatic string access_kind(input logic [6:0] op);
        if (op == `OPC_LOAD)
            return "load";
        else if (op == `OPC_STORE)
            return "store";
        return "other";
    endfunction

    task automatic load_vectors(output bit ok);
        int fd;
        fd = $fopen(VEC_FILE, "r");
        ok = 1'b0;
        if (fd == 0)
            $display("Vector file %s is missing or cannot be read", VEC_FILE);
        else
        begin
            $fclose(fd);
            $readmemh(VEC_FILE, vec_raw);
            while (vec_count < MAX_VEC && !$isunknown(vec_raw[vec_count*FIELDS]))
                vec_count++;
            if (vec_count == 0)
                $display("Vector file %s holds no vectors", VEC_FILE);
            else
                ok = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // Drive and check, one access per cycle
    // ------------------------------------------------------------
    task automatic drive_access(input int k);
        word_t flags;
        flags = vec_field(k, 8);
        opcode     <= 7'(vec_field(k, 0));
        funct3     <= 3'(vec_field(k, 1));
        addr       <= vec_field(k, 2);
        store_data <= vec_field(k, 3);
        io_rx_data <= vec_field(k, 4);
        // Fetch vectors read imem at addr, others fetch at random
        fetch_addr <= flags[3] ? vec_field(k, 2) : word_t'($urandom);
    endtask

    task automatic drive_idle();
        opcode     <= 7'h00;
        funct3     <= 3'h0;
        addr       <= '0;
        store_data <= '0;
        io_rx_data <= '0;
        fetch_addr <= word_t'($urandom);
    endtask

    task automatic report(input string what, input int errs);
        if (errs == 0)
        begin
            $display("%s ok", what);
            passed++;
        end
        else
        begin
            $display("%s FAILED with %0d errors", what, errs);
            failed++;
        end
    endtask

    task automatic check_results(input int k);
        word_t flags;
        int    e0;
        flags = vec_field(k, 8);
        e0    = errors;
        if (flags[0])
            check_word("load_data", load_data, vec_field(k, 5));
        if (flags[1])
            check_word("io_tx_data", io_tx_data, vec_field(k, 6));
        check_lanes("io_tx_lanes", io_tx_lanes, lane_mask_t'(vec_field(k, 7)));
        if (flags[3])
            check_word("fetch_instr", fetch_instr, vec_field(k, 5));
        vec_errs[k] += errors - e0;
        report($sformatf("vector %0d %s", k, access_kind(7'(vec_field(k, 0)))), vec_errs[k]);
    endtask

    task automatic run_vectors();
        word_t flags;
        int    e0;
        for (int k = 0; k <= vec_count; k++)
        begin
            @(posedge clk);
            if (k < vec_count)
                drive_access(k);
            else
                drive_idle();
            @(negedge clk);
            // Registered results belong to the previous access
            if (k > 0)
                check_results(k - 1);
            if (k < vec_count)
            begin
                flags = vec_field(k, 8);
                e0    = errors;
                check_bit("io_recv", io_recv, flags[2]);
                vec_errs[k] += errors - e0;
            end
        end
    endtask

    task automatic apply_reset();
        int e0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        e0 = errors;
        check_word("load_data", load_data, '0);
        check_word("io_tx_data", io_tx_data, '0);
        check_lanes("io_tx_lanes", io_tx_lanes, '0);
        check_bit("io_recv", io_recv, 1'b0);
        report("reset", errors - e0);
    endtask

    initial
    begin
        bit ok;
        clk        = 1'b0;
        reset      = 1'b1;
        opcode     = 7'h00;
        funct3     = 3'h0;
        addr       = '0;
        store_data = '0;
        fetch_addr = '0;
        io_rx_data = '0;
        void'($urandom(32'hd5040a57));
        load_vectors(ok);
        if (!ok)
        begin
            $display("** FAIL **");
            $finish;
        end
        else
        begin
            vec_loaded = 1'b1;
            apply_reset();
            run_vectors();
            $display("Tests passed %0d, failed %0d", passed, failed);
            if (errors == 0 && failed == 0)
                $display("** PASS **");
            else
                $display("** FAIL **");
            $finish;
        end
    end

    // Watchdog sized from the vector count
    initial
    begin
        wait (vec_loaded);
        #((vec_count + 10) * CLK_PERIOD);
        $display("Run timed out before all vectors finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: testbench/mem_vectors.txt
// opcode funct3 addr store_data io_rx_data exp_load exp_tx_data exp_tx_lanes flags
// flags: 1 load_data, 2 io_tx_data, 4 io_recv high, 8 fetch at addr into exp_load
23 2 10000000 A1B2C3D4 00000000 00000000 00000000 0 2
03 0 10000000 00000000 00000000 FFFFFFD4 00000000 0 3
03 4 10000002 00000000 00000000 000000B2 00000000 0 3
03 1 10000000 00000000 00000000 FFFFC3D4 00000000 0 3
03 5 10000002 00000000 00000000 0000A1B2 00000000 0 3
23 0 10000001 0000005E 00000000 00000000 00000000 0 2
23 0 10000003 00000077 00000000 00000000 00000000 0 2
23 1 10000002 0000F00D 00000000 00000000 00000000 0 2
03 1 10000002 00000000 00000000 FFFFF00D 00000000 0 3
23 0 10000000 000000FF 00000000 00000000 00000000 0 2
23 0 10000002 00000011 00000000 00000000 00000000 0 2
23 1 10000000 00009876 00000000 00000000 00000000 0 2
03 2 10000000 00000000 00000000 F0119876 00000000 0 3
03 0 10000003 00000000 00000000 FFFFFFF0 00000000 0 3
23 1 10000001 0000FFFF 00000000 00000000 00000000 0 2
23 2 10000002 DEADBEEF 00000000 00000000 00000000 0 2
13 2 10000000 55555555 00000000 00000000 00000000 0 2
03 2 10000000 00000000 00000000 F0119876 00000000 0 3
23 2 30000100 CAFEF00D 00000000 00000000 00000000 0 2
03 2 30000100 00000000 00000000 CAFEF00D 00000000 0 3
00 0 30000100 00000000 00000000 CAFEF00D 00000000 0 A
23 2 80000000 01234567 00000000 00000000 01234567 F 2
23 0 80000002 000000AB 00000000 00000000 01AB4567 4 2
23 1 80000001 00001234 00000000 00000000 01AB4567 0 2
03 2 80000000 00000000 89ABCDEF 89ABCDEF 01AB4567 0 7
03 0 80000001 00000000 89ABCDEF FFFFFFCD 01AB4567 0 7
03 5 80000002 00000000 12348001 00001234 01AB4567 0 7
03 2 40000000 00000000 00000000 00000000 01AB4567 0 3
03 0 C0000000 00000000 00000000 00000000 01AB4567 0 3

// File: verilog/byte_ram.sv
// Word RAM with byte-lane writes, a registered data read and a registered fetch read port
module byte_ram import mem_pkg::*; #(
    parameter int DEPTH = 1024
) (
    input  logic       clk,
    input  lane_mask_t we,
    input  word_t      addr,
    input  word_t      wdata,
    output word_t      rdata,
    input  word_t      fetch_addr,
    output word_t      fetch_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t         mem [DEPTH];
    logic [AW-1:0] idx;
    logic [AW-1:0] fetch_idx;

    // Word index, byte offset dropped
    assign idx       = addr[AW+1:2];
    assign fetch_idx = fetch_addr[AW+1:2];

    // ------------------------------------------------------------
    // Lane writes and both read ports
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (we[i])
                mem[idx][8*i +: 8] <= wdata[8*i +: 8];
        end
        // Read returns the old word on a same-cycle write
        rdata      <= mem[idx];
        fetch_data <= mem[fetch_idx];
    end

    // Word offset inside the 256 MB region must fit the RAM
    a_index_range: assert property (@(posedge clk) (|we) |-> (addr[27:2] < DEPTH))
        else $error("byte_ram: write word %0d beyond depth %0d", addr[27:2], DEPTH);

endmodule

// File: verilog/io_port.sv
// Memory-mapped I/O port with a lane-merged transmit register and a captured receive word
module io_port import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  lane_mask_t we,
    input  word_t      wdata,
    input  word_t      rx_data,
    input  logic       recv,
    output word_t      tx_data,
    output lane_mask_t tx_lanes,
    output word_t      rx_word
);

    // ------------------------------------------------------------
    // Transmit side
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tx_data  <= '0;
            tx_lanes <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (we[i])
                    tx_data[8*i +: 8] <= wdata[8*i +: 8];
            end
            // Mask shows for one cycle, then drops back to zero
            tx_lanes <= we;
        end
    end

    // ------------------------------------------------------------
    // Receive side
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            rx_word <= '0;
        else if (recv)
            rx_word <= rx_data;
    end

endmodule

// File: verilog/load_extract.sv
// Registers a load's width, offset and source, then selects and extends the returned data
`include "riscv_mem_defs.svh"

module load_extract import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] funct3,
    input  logic [1:0] offset,
    input  load_src_t  load_src,
    input  word_t      dmem_rdata,
    input  word_t      io_word,
    output word_t      load_data
);

    logic [2:0]  funct3_q;
    logic [1:0]  offset_q;
    load_src_t   src_q;
    word_t       src_word;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // Source returns to none on reset so load_data reads zero
    always_ff @(posedge clk)
    begin
        if (reset)
            src_q <= SRC_NONE;
        else
            src_q <= load_src;
    end

    always_ff @(posedge clk)
    begin
        funct3_q <= funct3;
        offset_q <= offset;
    end

    // ------------------------------------------------------------
    // Source select and extension
    // ------------------------------------------------------------
    always_comb
    begin
        case (src_q)
            SRC_DMEM: src_word = dmem_rdata;
            SRC_IO:   src_word = io_word;
            default:  src_word = '0;
        endcase
        ld_byte = src_word[8*offset_q +: 8];
        // Misaligned halfwords fall back to their aligned half
        ld_half = offset_q[1] ? src_word[31:16] : src_word[15:0];
        case (funct3_q)
            `FNC_B:  load_data = {{24{ld_byte[7]}}, ld_byte};
            `FNC_BU: load_data = {24'h000000, ld_byte};
            `FNC_H:  load_data = {{16{ld_half[15]}}, ld_half};
            `FNC_HU: load_data = {16'h0000, ld_half};
            default: load_data = src_word;
        endcase
    end

endmodule

// File: verilog/mem_control.sv
// Combinational decode of each access into per-region byte-lane enables and the I/O receive strobe
`include "riscv_mem_defs.svh"

module mem_control import mem_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  word_t      addr,
    output lane_mask_t dmem_we,
    output lane_mask_t imem_we,
    output lane_mask_t io_we,
    output logic       io_recv,
    output load_src_t  load_src
);

    lane_mask_t mask;
    logic       in_dmem;
    logic       in_imem;
    logic       in_io;

    // Region hits, 0x3xxx_xxxx hits both RAMs
    assign in_dmem = !addr[31] && addr[`DMEM_BIT];
    assign in_imem = !addr[31] && addr[`IMEM_BIT];
    assign in_io   = (addr[31:28] == `IO_REGION);

    // ------------------------------------------------------------
    // Lane mask from width and offset
    // ------------------------------------------------------------
    always_comb
    begin
        case (funct3)
            `FNC_B:
                mask = lane_mask_t'(4'b0001 << addr[1:0]);
            `FNC_H:
            begin
                case (addr[1:0])
                    2'b00:   mask = 4'b0011;
                    2'b10:   mask = 4'b1100;
                    default: mask = 4'b0000;  // odd offset writes nothing
                endcase
            end
            `FNC_W:
                mask = (addr[1:0] == 2'b00) ? 4'b1111 : 4'b0000;
            default:
                mask = 4'b0000;
        endcase
    end

    // ------------------------------------------------------------
    // Region gating and load source
    // ------------------------------------------------------------
    always_comb
    begin
        dmem_we  = '0;
        imem_we  = '0;
        io_we    = '0;
        io_recv  = 1'b0;
        load_src = SRC_NONE;
        case (opcode)
            `OPC_STORE:
            begin
                if (in_dmem)
                    dmem_we = mask;
                if (in_imem)
                    imem_we = mask;
                if (in_io)
                    io_we = mask;
            end
            `OPC_LOAD:
            begin
                if (in_io)
                begin
                    io_recv  = 1'b1;
                    load_src = SRC_IO;
                end
                else if (in_dmem)
                    load_src = SRC_DMEM;
            end
            default:
                load_src = SRC_NONE;
        endcase
    end

    // A store never reaches both dmem and the I/O port
    a_region_excl: assert final ($isunknown(addr) || !((|dmem_we) && (|io_we)))
        else $error("mem_control: dmem and I/O written together, addr %h", addr);

    // A byte store touches at most one lane in any region
    a_sb_one_lane: assert final ($isunknown({opcode, funct3, addr}) ||
                                 !(opcode == `OPC_STORE && funct3 == `FNC_B) ||
                                 $onehot0(dmem_we | imem_we | io_we))
        else $error("mem_control: SB enabled several lanes, addr %h", addr);

endmodule

// File: verilog/mem_pkg.sv
// Data types shared by the memory-side blocks, imported by every RTL module and the testbench
package mem_pkg;

    // One 32-bit data word, four byte lanes wide
    typedef logic [31:0] word_t;

    // One enable bit per byte lane, bit 0 is the least significant byte
    typedef logic [3:0] lane_mask_t;

    // Where a load is served from
    // SRC_NONE returns zero for unmapped addresses and non-load cycles
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_DMEM = 2'd1,
        SRC_IO   = 2'd2
    } load_src_t;

endpackage

// File: verilog/mem_subsystem.sv
// Top level of the data-memory side, connecting decode, alignment, both RAMs, I/O and load return
`include "riscv_mem_defs.svh"

module mem_subsystem import mem_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  word_t      addr,
    input  word_t      store_data,
    input  word_t      fetch_addr,
    input  word_t      io_rx_data,
    output word_t      load_data,
    output word_t      fetch_instr,
    output word_t      io_tx_data,
    output lane_mask_t io_tx_lanes,
    output logic       io_recv
);

    lane_mask_t dmem_we;
    lane_mask_t imem_we;
    lane_mask_t io_we;
    load_src_t  load_src;
    word_t      wdata;
    word_t      dmem_rdata;
    word_t      io_rx_word;

    // ------------------------------------------------------------
    // Access decode and store data
    // ------------------------------------------------------------
    mem_control mem_control_inst (
        .opcode   (opcode),
        .funct3   (funct3),
        .addr     (addr),
        .dmem_we  (dmem_we),
        .imem_we  (imem_we),
        .io_we    (io_we),
        .io_recv  (io_recv),
        .load_src (load_src)
    );

    store_align store_align_inst (
        .funct3     (funct3),
        .offset     (addr[1:0]),
        .store_data (store_data),
        .wdata      (wdata)
    );

    // ------------------------------------------------------------
    // Memories and I/O
    // ------------------------------------------------------------
    // Data RAM, fetch port not used
    byte_ram #(.DEPTH(`DMEM_DEPTH)) dmem_ram (
        .clk        (clk),
        .we         (dmem_we),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (dmem_rdata),
        .fetch_addr ('0),
        .fetch_data ()
    );

    // Instruction RAM, loads never read it through the data port
    byte_ram #(.DEPTH(`IMEM_DEPTH)) imem_ram (
        .clk        (clk),
        .we         (imem_we),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_instr)
    );

    io_port io_port_inst (
        .clk      (clk),
        .reset    (reset),
        .we       (io_we),
        .wdata    (wdata),
        .rx_data  (io_rx_data),
        .recv     (io_recv),
        .tx_data  (io_tx_data),
        .tx_lanes (io_tx_lanes),
        .rx_word  (io_rx_word)
    );

    load_extract load_extract_inst (
        .clk        (clk),
        .reset      (reset),
        .funct3     (funct3),
        .offset     (addr[1:0]),
        .load_src   (load_src),
        .dmem_rdata (dmem_rdata),
        .io_word    (io_rx_word),
        .load_data  (load_data)
    );

endmodule

// File: verilog/riscv_mem_defs.svh
// Opcode, funct3, region and depth macros shared by the memory-side RTL and its testbench
`ifndef RISCV_MEM_DEFS_SVH
`define RISCV_MEM_DEFS_SVH

// ------------------------------------------------------------
// RV32I major opcodes
// ------------------------------------------------------------
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

// ------------------------------------------------------------
// Access width codes carried in funct3
// ------------------------------------------------------------
`define FNC_B       3'b000
`define FNC_H       3'b001
`define FNC_W       3'b010
`define FNC_BU      3'b100
`define FNC_HU      3'b101

// Address bits 31..28 of the memory-mapped I/O window
`define IO_REGION   4'b1000

// Region select bits, valid only while bit 31 is clear
`define DMEM_BIT    28
`define IMEM_BIT    29

// Word counts of the two RAMs
`define DMEM_DEPTH  1024
`define IMEM_DEPTH  1024

`endif

// File: verilog/store_align.sv
// Places store data into the byte lanes that the access width and address offset target
`include "riscv_mem_defs.svh"

module store_align import mem_pkg::*; (
    input  logic [2:0] funct3,
    input  logic [1:0] offset,
    input  word_t      store_data,
    output word_t      wdata
);

    logic [7:0]  st_byte;
    logic [15:0] st_half;

    assign st_byte = store_data[7:0];
    assign st_half = store_data[15:0];

    // ------------------------------------------------------------
    // Lane placement
    // ------------------------------------------------------------
    always_comb
    begin
        case (funct3)
            `FNC_B:
                // Byte goes to lane offset, other lanes are don't-care
                wdata = word_t'(st_byte) << (8 * offset);
            `FNC_H:
            begin
                if (offset[1])
                    wdata = {st_half, 16'h0000};
                else
                    wdata = {16'h0000, st_half};
            end
            default:
                wdata = store_data;
        endcase
    end

endmodule
